// File: Bender.yml
package:
  name: mem_subsys

sources:
  # package first, then leaf to top
  - files:
      - source/spram_pkg.sv
      - source/spram_bank.sv
      - source/spram32_32k.sv
      - source/mem_port.sv
      - source/mem_subsys_top.sv

  # testbench with the included reference model
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mem_subsys_tb.sv

// File: mem_subsys_top.f
+incdir+verification
source/spram_pkg.sv
source/spram_bank.sv
source/spram32_32k.sv
source/mem_port.sv
source/mem_subsys_top.sv
verification/mem_subsys_tb.sv

// File: source/mem_port.sv
// **********************************************************************
// Valid/ready front end for the single-port memory. Forwards accepted
// requests, tracks one read held in the banks and moves it into a
// registered response with its own valid/ready.
// **********************************************************************
module mem_port (
    input  logic                         clk,
    input  logic                         arst_n,

    // request channel
    input  spram_pkg::mem_req_t          req,
    input  logic                         req_valid,
    output logic                         req_ready,

    // response channel
    output spram_pkg::mem_rsp_t          rsp,
    output logic                         rsp_valid,
    input  logic                         rsp_ready,

    // memory side
    output spram_pkg::mem_req_t          mem_req,
    output logic                         mem_en,
    input  logic [spram_pkg::data_w-1:0] rdata
);
    logic accept;                    // request taken this edge
    logic rd_accept;
    logic pending;                   // read data waiting in the banks
    logic load;                      // banks -> response register
    logic drain;                     // response consumed

    assign drain = rsp_valid & rsp_ready;

    // response register is free now or frees at this edge
    assign load = pending & (~rsp_valid | rsp_ready);

    // a new access would overwrite the held bank output
    assign req_ready = ~pending | load;

    assign accept    = req_valid & req_ready;
    assign rd_accept = accept & ~req.we;

    // access goes to the banks at the accepting edge
    assign mem_en  = accept;
    assign mem_req = req;

    // pending read tracking, a new read refills it as the old one leaves
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (rd_accept) begin
            pending <= 1'b1;
        end else if (load) begin
            pending <= 1'b0;
        end
    end

    // response valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (load) begin
            rsp_valid <= 1'b1;
        end else if (drain) begin
            rsp_valid <= 1'b0;
        end
    end

    // response data, held while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            rsp.rdata <= rdata;
        end
    end

endmodule : mem_port

// File: source/mem_subsys_top.sv
// **********************************************************************
// Memory subsystem top. Joins the request/response front end to the
// 32K x 32 banked memory.
// **********************************************************************
module mem_subsys_top (
    input  logic                clk,
    input  logic                arst_n,
    input  spram_pkg::mem_req_t req,
    input  logic                req_valid,
    output logic                req_ready,
    output spram_pkg::mem_rsp_t rsp,
    output logic                rsp_valid,
    input  logic                rsp_ready
);
    import spram_pkg::*;

    mem_req_t          mem_req;     // accepted access
    logic              mem_en;
    logic [data_w-1:0] rdata;       // held bank output

    mem_port u_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .mem_req   (mem_req),
        .mem_en    (mem_en),
        .rdata     (rdata)
    );

    spram32_32k u_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (mem_en),
        .req    (mem_req),
        .rdata  (rdata)
    );

endmodule : mem_subsys_top

// File: source/spram32_32k.sv
// **********************************************************************
// 32K x 32 byte-maskable memory from four 16K x 16 banks.
// Addr bit 14 picks the bank pair, read data shows up one cycle later
// and holds until the next read.
// **********************************************************************
module spram32_32k (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       en,      // access this cycle
    input  spram_pkg::mem_req_t        req,
    output logic [spram_pkg::data_w-1:0] rdata
);
    import spram_pkg::*;

    logic              hi;                      // upper range select
    logic              cs_lo;
    logic              cs_hi;
    logic [mask_w-1:0] msk0;                    // low half nibble mask
    logic [mask_w-1:0] msk1;                    // high half nibble mask
    logic [data_w-1:0] vo_lo;
    logic [data_w-1:0] vo_hi;
    logic              sel_q;                   // pair that holds last read

    assign hi    = req.addr[addr_w-1];
    assign cs_lo = en & ~hi;
    assign cs_hi = en & hi;

    // each byte enable covers two nibbles
    assign msk0 = {req.be[1], req.be[1], req.be[0], req.be[0]};
    assign msk1 = {req.be[3], req.be[3], req.be[2], req.be[2]};

    // remember which pair was read, later requests must not move rdata
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_q <= 1'b0;
        end else if (en && !req.we) begin
            sel_q <= hi;
        end
    end

    assign rdata = sel_q ? vo_hi : vo_lo;

    spram_bank bank00 (
        .clk     (clk),
        .cs      (cs_lo),
        .we      (req.we),
        .addr    (req.addr[bank_addr_w-1:0]),
        .din     (req.wdata[half_w-1:0]),
        .mask_we (msk0),
        .dout    (vo_lo[half_w-1:0])
    );

    spram_bank bank01 (
        .clk     (clk),
        .cs      (cs_lo),
        .we      (req.we),
        .addr    (req.addr[bank_addr_w-1:0]),
        .din     (req.wdata[data_w-1:half_w]),
        .mask_we (msk1),
        .dout    (vo_lo[data_w-1:half_w])
    );

    spram_bank bank10 (
        .clk     (clk),
        .cs      (cs_hi),
        .we      (req.we),
        .addr    (req.addr[bank_addr_w-1:0]),
        .din     (req.wdata[half_w-1:0]),
        .mask_we (msk0),
        .dout    (vo_hi[half_w-1:0])
    );

    spram_bank bank11 (
        .clk     (clk),
        .cs      (cs_hi),
        .we      (req.we),
        .addr    (req.addr[bank_addr_w-1:0]),
        .din     (req.wdata[data_w-1:half_w]),
        .mask_we (msk1),
        .dout    (vo_hi[data_w-1:half_w])
    );

endmodule : spram32_32k

// File: source/spram_bank.sv
// **********************************************************************
// Behavioral 16K x 16 single-port RAM bank with nibble write mask.
// dout loads only on a selected read and holds through writes and idle.
// **********************************************************************
module spram_bank (
    input  logic                            clk,
    input  logic                            cs,       // bank select
    input  logic                            we,
    input  logic [spram_pkg::bank_addr_w-1:0] addr,
    input  logic [spram_pkg::half_w-1:0]    din,
    input  logic [spram_pkg::mask_w-1:0]    mask_we,  // one bit per nibble
    output logic [spram_pkg::half_w-1:0]    dout
);
    import spram_pkg::*;

    logic [half_w-1:0] mem [bank_words];              // storage, no reset

    // write path, only the masked nibbles change
    always_ff @(posedge clk) begin
        if (cs && we) begin
            for (int i = 0; i < mask_w; i++) begin
                if (mask_we[i]) begin
                    mem[addr][i*nib_w +: nib_w] <= din[i*nib_w +: nib_w];
                end
            end
        end
    end

    // read port, output holds between reads
    always_ff @(posedge clk) begin
        if (cs && !we) begin
            dout <= mem[addr];
        end
    end

endmodule : spram_bank

// File: source/spram_pkg.sv
// **********************************************************************
// Shared sizes and bus structs for the 32K x 32 single-port memory
// subsystem. Imported by the RTL and the testbench.
// **********************************************************************
package spram_pkg;

    // memory geometry
    localparam int addr_w      = 15;           // 32K words
    localparam int bank_addr_w = 14;           // 16K words per bank
    localparam int data_w      = 32;
    localparam int half_w      = 16;           // one bank is half a word
    localparam int be_w        = data_w / 8;   // one enable per byte
    localparam int mask_w      = 4;            // nibble write mask per bank
    localparam int nib_w       = half_w / mask_w;

    localparam int bank_words  = 1 << bank_addr_w;

    // request toward the memory, one access per beat
    typedef struct packed {
        logic [addr_w-1:0] addr;               // word address
        logic [data_w-1:0] wdata;
        logic [be_w-1:0]   be;                 // byte enables, active high
        logic              we;                 // 1 = write
    } mem_req_t;

    // read response, writes return nothing
    typedef struct packed {
        logic [data_w-1:0] rdata;
    } mem_rsp_t;

endpackage : spram_pkg

// File: verification/mem_ref_model.svh
// ********************************************************************
// Reference model for the memory testbench. Holds a 32K-word array
// updated on accepted writes and queues of expected read responses.
// Included inside the testbench module after the package import.
// ********************************************************************
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

logic [data_w-1:0] ref_mem [1 << addr_w];    // model contents, filled by the testbench
logic [data_w-1:0] exp_data [$];             // expected reads, oldest first
logic [addr_w-1:0] exp_addr [$];
int                exp_cyc  [$];             // cycle count when the read was taken

// only the enabled bytes take new data
task automatic model_write(input mem_req_t r);
    for (int b = 0; b < be_w; b++) begin
        if (r.be[b]) begin
            ref_mem[r.addr][b*8 +: 8] = r.wdata[b*8 +: 8];
        end
    end
endtask

// reads return the word as it stands at acceptance
task automatic model_read(input mem_req_t r, input int c);
    exp_data.push_back(ref_mem[r.addr]);
    exp_addr.push_back(r.addr);
    exp_cyc.push_back(c);
endtask

`endif

// File: verification/mem_subsys_tb.sv
// ********************************************************************
// Testbench for the memory subsystem. Fills the memory, runs directed
// and random masked accesses under back-pressure and checks every
// response against the reference model.
// ********************************************************************
module mem_subsys_tb;
    import spram_pkg::*;

    localparam int seed_init  = 32'h5df7;
    localparam int n_random   = 3000;
    localparam int wait_limit = 200;          // cycles allowed per wait

    logic       clk;
    logic       arst_n;
    mem_req_t   req;
    logic       req_valid;
    logic       req_ready;
    mem_rsp_t   rsp;
    logic       rsp_valid;
    logic       rsp_ready;

    int         seed;
    int         ready_seed;
    int         cyc        = 0;
    int         err_cnt    = 0;
    int         chk_cnt    = 0;
    logic [1:0] ready_mode;                   // 0 random, 1 high, 2 low
    logic       check_lat;                    // latency check on responses
    logic       timed_out  = 1'b0;            // a wait ran out, later waits are skipped
    logic       held_valid = 1'b0;
    mem_rsp_t   held_rsp;

    `include "mem_ref_model.svh"

    mem_subsys_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // response back-pressure
    always @(posedge clk) begin
        case (ready_mode)
            2'd0:    rsp_ready <= ($random(ready_seed) & 3) != 0;  // mostly ready
            2'd1:    rsp_ready <= 1'b1;
            default: rsp_ready <= 1'b0;
        endcase
    end

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        err_cnt++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic check_rsp();
        logic [data_w-1:0] exp_word;
        logic [addr_w-1:0] addr;
        int                acc;
        chk_cnt++;
        assert (exp_data.size() > 0) else begin
            err_cnt++;
            $display("response %h arrived with no read outstanding", rsp.rdata);
        end
        if (exp_data.size() > 0) begin
            exp_word = exp_data.pop_front();
            addr     = exp_addr.pop_front();
            acc      = exp_cyc.pop_front();
            assert (rsp.rdata == exp_word) else begin
                err_cnt++;
                $display("[ERROR] %0t read addr %h expected %h got %h",
                         $time, addr, exp_word, rsp.rdata);
            end
            if (check_lat) begin
                assert (cyc - acc == 2) else begin
                    err_cnt++;
                    $display("[ERROR] %0t read addr %h response after %0d cycles, expected 2",
                             $time, addr, cyc - acc);
                end
            end
        end
    endtask

    // monitor samples at the falling edge away from the driving edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (req_valid && req_ready) begin
                if (req.we) begin
                    model_write(req);
                end else begin
                    model_read(req, cyc);
                end
            end
            if (held_valid) begin
                chk_cnt++;
                assert (rsp_valid && rsp == held_rsp) else begin
                    err_cnt++;
                    $display("[ERROR] %0t stalled response changed from %h to %h (valid %b)",
                             $time, held_rsp.rdata, rsp.rdata, rsp_valid);
                end
            end
            if (rsp_valid && rsp_ready) begin
                check_rsp();
            end
            held_valid = rsp_valid && !rsp_ready;
            held_rsp   = rsp;
        end
    end

    // entered at a rising edge and returns at the accepting edge
    task automatic wait_accept(input string what);
        int waited;
        waited = 0;
        if (!timed_out) begin
            @(negedge clk);
            while (!req_ready && waited < wait_limit) begin
                waited++;
                @(negedge clk);
            end
            if (!req_ready) begin
                timeout_fail({"req_ready on ", what});
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic send_req(input mem_req_t r);
        req       <= r;
        req_valid <= 1'b1;
        wait_accept("a request handshake");
        req_valid <= 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        if (!timed_out) begin
            @(negedge clk);
            while ((exp_data.size() > 0 || rsp_valid) && waited < wait_limit) begin
                waited++;
                @(negedge clk);
            end
            if (exp_data.size() > 0 || rsp_valid) begin
                timeout_fail({"responses to drain after ", what});
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic make_req(output mem_req_t r);
        int sel;
        int lo;
        sel = $random(seed);
        lo  = $random(seed);
        if (sel[6]) begin
            lo = lo & 15;                     // small pool so both halves share low addresses
        end
        r.we    = sel[0];
        r.be    = sel[4:1];                   // zero enables included
        r.wdata = $random(seed);
        r.addr  = {sel[5], lo[bank_addr_w-1:0]};
    endtask

    initial begin
        mem_req_t r;
        int       accepted;
        logic     stalled;
        int       gap;
        seed       = seed_init;
        ready_seed = seed_init;
        check_lat  <= 1'b0;
        ready_mode <= 2'd1;
        arst_n     <= 1'b0;
        req        <= '0;
        req_valid  <= 1'b0;
        rsp_ready  <= 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        chk_cnt++;
        assert (req_ready && !rsp_valid) else begin
            err_cnt++;
            $display("[ERROR] %0t after reset req_ready=%b rsp_valid=%b",
                     $time, req_ready, rsp_valid);
        end
        @(posedge clk);

        // fill every word so reads have known contents
        for (int a = 0; a < (1 << addr_w); a++) begin
            r.addr  = a[addr_w-1:0];
            r.wdata = $random(seed);
            r.be    = '1;
            r.we    = 1'b1;
            send_req(r);
        end

        // same low address in both halves
        r.be    = '1;
        r.we    = 1'b1;
        r.addr  = 15'h0005;
        r.wdata = 32'h1111_aaaa;
        send_req(r);
        r.addr  = 15'h4005;
        r.wdata = 32'h2222_bbbb;
        send_req(r);
        r.we    = 1'b0;
        r.addr  = 15'h0005;
        send_req(r);
        r.addr  = 15'h4005;
        send_req(r);
        wait_drain("the half-select reads");

        // back-to-back reads at one response per cycle
        check_lat <= 1'b1;
        repeat (8) begin
            make_req(r);
            r.we = 1'b0;
            send_req(r);
        end
        wait_drain("the back-to-back reads");
        check_lat <= 1'b0;

        // reads with the response side stalled
        ready_mode <= 2'd2;
        idle_cycles(2);
        accepted = 0;
        stalled  = 1'b0;
        make_req(r);
        r.we = 1'b0;
        req       <= r;
        req_valid <= 1'b1;
        while (!stalled && accepted < 8) begin
            @(negedge clk);
            if (req_ready) begin
                @(posedge clk);
                accepted++;
                make_req(r);
                r.we = 1'b0;
                req <= r;
            end else begin
                stalled = 1'b1;
            end
        end
        chk_cnt++;
        assert (accepted == 2) else begin
            err_cnt++;
            $display("[ERROR] %0t %0d reads taken with rsp_ready low, expected 2",
                     $time, accepted);
        end
        @(posedge clk);
        ready_mode <= 2'd1;
        wait_accept("the stalled read");
        req_valid <= 1'b0;
        wait_drain("the stalled reads");

        // random traffic under random back-pressure
        ready_mode <= 2'd0;
        repeat (n_random) begin
            make_req(r);
            send_req(r);
            gap = $random(seed) & 7;
            if (gap > 4) begin
                idle_cycles(gap - 4);
            end
        end
        ready_mode <= 2'd1;
        wait_drain("the random traffic");
        finish_run();
    end

endmodule : mem_subsys_tb
